//--- pong_geom_pkg.sv
// Field geometry for a 160x120 frame buffer; sprites are placed so that no pixel ever leaves it
`default_nettype none

package pong_geom_pkg;

	localparam int SCREEN_W = 160;
	localparam int SCREEN_H = 120;

	localparam int X_W = 8;
	localparam int Y_W = 7;
	localparam int COLOUR_W = 3;

	localparam logic [COLOUR_W-1:0] COLOUR_BLACK = 3'd0;
	localparam logic [COLOUR_W-1:0] COLOUR_BALL = 3'd7;

	localparam int BALL_SIZE = 2;
	localparam int PADDLE_W = 2;
	localparam int PADDLE_H = 8;

	// Paddles sit in the outermost columns
	localparam logic [X_W-1:0] PADDLE_L_X = 8'd0;
	localparam logic [X_W-1:0] PADDLE_R_X = X_W'(SCREEN_W - PADDLE_W);

	localparam logic [Y_W-1:0] PADDLE_Y_START = 7'd55;
	localparam logic [Y_W-1:0] PADDLE_Y_MAX = Y_W'(SCREEN_H - PADDLE_H);

	localparam logic [X_W-1:0] BALL_X_START = 8'd79;
	localparam logic [Y_W-1:0] BALL_Y_START = 7'd59;
	localparam logic [Y_W-1:0] BALL_Y_MAX = Y_W'(SCREEN_H - BALL_SIZE);

	// Ball columns where a paddle face is tested
	localparam logic [X_W-1:0] HIT_X_L = X_W'(PADDLE_W);
	localparam logic [X_W-1:0] HIT_X_R = X_W'(SCREEN_W - PADDLE_W - BALL_SIZE);

	localparam int SPRITE_PIXELS = BALL_SIZE * BALL_SIZE + 2 * PADDLE_W * PADDLE_H;

endpackage

`default_nettype wire

//--- pong_rules_pkg.sv
// Game rule encodings; only six of the eight direction codes are reached in play
`default_nettype none

package pong_rules_pkg;

	localparam int DIR_W = 3;

	localparam logic [DIR_W-1:0] DIR_L = 3'd0;
	localparam logic [DIR_W-1:0] DIR_UL = 3'd1;
	localparam logic [DIR_W-1:0] DIR_U = 3'd2; // Kept for the encoding, never entered
	localparam logic [DIR_W-1:0] DIR_UR = 3'd3;
	localparam logic [DIR_W-1:0] DIR_R = 3'd4;
	localparam logic [DIR_W-1:0] DIR_DR = 3'd5;
	localparam logic [DIR_W-1:0] DIR_D = 3'd6; // Likewise
	localparam logic [DIR_W-1:0] DIR_DL = 3'd7;

	localparam int SCORE_W = 4;
	localparam logic [SCORE_W-1:0] SCORE_MAX = 4'd15;

	localparam int SPEED_W = 2;

	// Frames per game step for each speed code
	localparam int MULT_NORMAL = 2; // Code 0
	localparam int MULT_SLOW = 4; // Code 1
	localparam int MULT_FAST = 1; // Codes 2 and 3

endpackage

`default_nettype wire

//--- frame_timer.sv
// One-shot period timer; TICKS_PER_FRAME must be 2 or more and speed is sampled only at timer_start
`timescale 1ns/100ps
`default_nettype none

module frame_timer #(
	parameter int TICKS_PER_FRAME = 100000
) (
	input logic clk,
	input logic reset_n,
	input logic timer_start,
	input logic [pong_rules_pkg::SPEED_W-1:0] speed,
	output logic frame_tick
);

	localparam int TICK_W = $clog2(TICKS_PER_FRAME);
	localparam int FRAME_W = $clog2(pong_rules_pkg::MULT_SLOW) + 1;

	logic running;
	logic [TICK_W-1:0] tick_cnt;
	logic [FRAME_W-1:0] frame_cnt;
	logic [FRAME_W-1:0] frames_left;

	// Multiplier minus one, loaded into the frame counter
	always_comb begin
		case (speed)
			2'd0: frames_left = FRAME_W'(pong_rules_pkg::MULT_NORMAL - 1);
			2'd1: frames_left = FRAME_W'(pong_rules_pkg::MULT_SLOW - 1);
			default: frames_left = FRAME_W'(pong_rules_pkg::MULT_FAST - 1);
		endcase
	end

	assign frame_tick = running && tick_cnt == '0 && frame_cnt == '0;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			running <= 1'b0;
			tick_cnt <= '0;
			frame_cnt <= '0;
		end else if (timer_start) begin
			running <= 1'b1;
			tick_cnt <= TICK_W'(TICKS_PER_FRAME - 1);
			frame_cnt <= frames_left;
		end else if (running) begin
			if (tick_cnt != '0) begin
				tick_cnt <= tick_cnt - 1'b1;
			end else if (frame_cnt != '0) begin
				frame_cnt <= frame_cnt - 1'b1; // Next frame of the period
				tick_cnt <= TICK_W'(TICKS_PER_FRAME - 1);
			end else begin
				running <= 1'b0;
			end
		end
	end

	// A tick ends the period, so no second tick follows without a new start
	a_tick_once: assert property (@(posedge clk) disable iff (!reset_n)
		frame_tick |=> !running && !frame_tick)
		else $error("frame_timer ticked while idle");

endmodule

`default_nettype wire

//--- game_fsm.sv
// Frame sequencer; go is taken once after reset and the draw, hold, erase, step loop then never stops
`timescale 1ns/100ps
`default_nettype none

module game_fsm (
	input logic clk,
	input logic reset_n,
	input logic go,
	input logic paint_done,
	input logic frame_tick,
	output logic paint_start,
	output logic erase_mode,
	output logic timer_start,
	output logic step
);

	localparam logic [2:0] IDLE = 3'd0;
	localparam logic [2:0] DRAW = 3'd1;
	localparam logic [2:0] HOLD = 3'd2;
	localparam logic [2:0] ERASE = 3'd3;
	localparam logic [2:0] STEP = 3'd4;

	logic [2:0] state;
	logic launch; // Start of the very first draw burst

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= IDLE;
			launch <= 1'b0;
			timer_start <= 1'b0;
		end else begin
			launch <= 1'b0;
			timer_start <= 1'b0;
			case (state)
				IDLE: begin
					if (go) begin
						state <= DRAW;
						launch <= 1'b1;
					end
				end
				DRAW: begin
					if (paint_done) begin
						state <= HOLD;
						timer_start <= 1'b1;
					end
				end
				HOLD: if (frame_tick) state <= ERASE;
				ERASE: if (paint_done) state <= STEP;
				STEP: state <= DRAW;
				default: state <= IDLE;
			endcase
		end
	end

	// Bursts are launched in the cycle the FSM moves into DRAW or ERASE,
	// so the painter's first write lands on the first cycle there
	assign paint_start = launch || (state == HOLD && frame_tick) || state == STEP;
	assign erase_mode = state == ERASE;
	assign step = state == STEP;

	// The timer is never started alongside a paint or a game step
	a_strobes_apart: assert property (@(posedge clk) disable iff (!reset_n)
		timer_start |-> !paint_start && !step)
		else $error("timer_start overlaps another strobe");

endmodule

`default_nettype wire

//--- sprite_painter.sv
// Writes ball, left paddle, right paddle in a fixed 36-pixel order; positions must hold during a burst
`timescale 1ns/100ps
`default_nettype none

module sprite_painter (
	input logic clk,
	input logic reset_n,
	input logic paint_start,
	input logic erase_mode,
	input logic [pong_geom_pkg::X_W-1:0] ball_x,
	input logic [pong_geom_pkg::Y_W-1:0] ball_y,
	input logic [pong_geom_pkg::Y_W-1:0] paddle_l_y,
	input logic [pong_geom_pkg::Y_W-1:0] paddle_r_y,
	input logic [pong_geom_pkg::COLOUR_W-1:0] p1_colour,
	input logic [pong_geom_pkg::COLOUR_W-1:0] p2_colour,
	output logic [pong_geom_pkg::X_W-1:0] pix_x,
	output logic [pong_geom_pkg::Y_W-1:0] pix_y,
	output logic [pong_geom_pkg::COLOUR_W-1:0] pix_colour,
	output logic plot,
	output logic paint_done
);

	localparam int BALL_PIX = pong_geom_pkg::BALL_SIZE * pong_geom_pkg::BALL_SIZE;
	localparam int PADDLE_PIX = pong_geom_pkg::PADDLE_W * pong_geom_pkg::PADDLE_H;
	localparam logic [5:0] L_BASE = 6'(BALL_PIX);
	localparam logic [5:0] R_BASE = 6'(BALL_PIX + PADDLE_PIX);
	localparam logic [5:0] LAST_IDX = 6'(pong_geom_pkg::SPRITE_PIXELS - 1);

	logic active;
	logic [5:0] idx;
	logic [3:0] rel; // Pixel number inside the current sprite
	logic [pong_geom_pkg::X_W-1:0] org_x;
	logic [pong_geom_pkg::Y_W-1:0] org_y;
	logic [pong_geom_pkg::COLOUR_W-1:0] colour;

	always_comb begin
		if (idx < L_BASE) begin
			rel = idx[3:0];
			org_x = ball_x;
			org_y = ball_y;
			colour = pong_geom_pkg::COLOUR_BALL;
		end else if (idx < R_BASE) begin
			rel = 4'(idx - L_BASE);
			org_x = pong_geom_pkg::PADDLE_L_X;
			org_y = paddle_l_y;
			colour = p1_colour;
		end else begin
			rel = 4'(idx - R_BASE);
			org_x = pong_geom_pkg::PADDLE_R_X;
			org_y = paddle_r_y;
			colour = p2_colour;
		end
	end

	// All sprites are two pixels wide, so the same split of rel works for each
	assign pix_x = org_x + pong_geom_pkg::X_W'(rel[0]);
	assign pix_y = org_y + pong_geom_pkg::Y_W'(rel[3:1]);
	assign pix_colour = erase_mode ? pong_geom_pkg::COLOUR_BLACK : colour;
	assign plot = active;
	assign paint_done = active && idx == LAST_IDX;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			active <= 1'b0;
			idx <= '0;
		end else if (paint_start) begin
			active <= 1'b1;
			idx <= '0;
		end else if (active) begin
			if (idx == LAST_IDX) begin
				active <= 1'b0;
				idx <= '0;
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

	a_no_overlap: assert property (@(posedge clk) disable iff (!reset_n)
		paint_start |-> !active)
		else $error("paint_start during a running burst");

endmodule

`default_nettype wire

//--- play_field.sv
// Game state; one rule step per step strobe, with the wall check taken after any paddle deflection
`timescale 1ns/100ps
`default_nettype none

module play_field (
	input logic clk,
	input logic reset_n,
	input logic step,
	input logic p1_up,
	input logic p1_down,
	input logic p2_up,
	input logic p2_down,
	output logic [pong_geom_pkg::X_W-1:0] ball_x,
	output logic [pong_geom_pkg::Y_W-1:0] ball_y,
	output logic [pong_geom_pkg::Y_W-1:0] paddle_l_y,
	output logic [pong_geom_pkg::Y_W-1:0] paddle_r_y,
	output logic [pong_rules_pkg::SCORE_W-1:0] score_l,
	output logic [pong_rules_pkg::SCORE_W-1:0] score_r
);

	logic [pong_rules_pkg::DIR_W-1:0] dir;
	logic [pong_rules_pkg::DIR_W-1:0] dir_n;
	logic [pong_geom_pkg::X_W-1:0] ball_x_n;
	logic [pong_geom_pkg::Y_W-1:0] ball_y_n;
	logic [pong_geom_pkg::Y_W-1:0] pl_n;
	logic [pong_geom_pkg::Y_W-1:0] pr_n;
	logic [pong_rules_pkg::SCORE_W-1:0] sl_n;
	logic [pong_rules_pkg::SCORE_W-1:0] sr_n;
	logic [pong_geom_pkg::Y_W:0] d_l; // Ball row relative to paddle top, MSB set if above it
	logic [pong_geom_pkg::Y_W:0] d_r;
	logic moving_left;
	logic moving_right;
	logic wrap;

	// Down wins over up when its own limit allows
	function automatic logic [pong_geom_pkg::Y_W-1:0] paddle_next(
		input logic [pong_geom_pkg::Y_W-1:0] y,
		input logic up,
		input logic down
	);
		logic [pong_geom_pkg::Y_W-1:0] n;
		n = y;
		if (up && y != '0) n = y - 1'b1;
		if (down && y < pong_geom_pkg::PADDLE_Y_MAX) n = y + 1'b1;
		return n;
	endfunction

	// Three zones down the paddle face
	function automatic logic [pong_rules_pkg::DIR_W-1:0] deflect(
		input logic [2:0] d,
		input logic [pong_rules_pkg::DIR_W-1:0] top,
		input logic [pong_rules_pkg::DIR_W-1:0] mid,
		input logic [pong_rules_pkg::DIR_W-1:0] bottom
	);
		if (d <= 3'd2) return top;
		else if (d <= 3'd4) return mid;
		else return bottom;
	endfunction

	assign d_l = {1'b0, ball_y} - {1'b0, paddle_l_y};
	assign d_r = {1'b0, ball_y} - {1'b0, paddle_r_y};
	assign moving_left = dir inside {pong_rules_pkg::DIR_L, pong_rules_pkg::DIR_UL,
		pong_rules_pkg::DIR_DL};
	assign moving_right = dir inside {pong_rules_pkg::DIR_R, pong_rules_pkg::DIR_UR,
		pong_rules_pkg::DIR_DR};

	always_comb begin
		pl_n = paddle_next(paddle_l_y, p1_up, p1_down);
		pr_n = paddle_next(paddle_r_y, p2_up, p2_down);
		sl_n = score_l;
		sr_n = score_r;
		wrap = 1'b0;
		dir_n = dir;
		ball_x_n = ball_x;
		ball_y_n = ball_y;
		if (ball_x == '0 || ball_x >= pong_geom_pkg::PADDLE_R_X) begin
			if (ball_x == '0) begin
				wrap = score_r == pong_rules_pkg::SCORE_MAX;
				sr_n = wrap ? '0 : score_r + 1'b1;
			end else begin
				wrap = score_l == pong_rules_pkg::SCORE_MAX;
				sl_n = wrap ? '0 : score_l + 1'b1;
			end
			ball_x_n = pong_geom_pkg::BALL_X_START; // Serve again, no move this step
			ball_y_n = pong_geom_pkg::BALL_Y_START;
			dir_n = pong_rules_pkg::DIR_L;
		end else begin
			if (ball_x == pong_geom_pkg::HIT_X_L && moving_left && d_l[pong_geom_pkg::Y_W:3] == '0)
				dir_n = deflect(d_l[2:0], pong_rules_pkg::DIR_UR, pong_rules_pkg::DIR_R,
					pong_rules_pkg::DIR_DR);
			if (ball_x == pong_geom_pkg::HIT_X_R && moving_right && d_r[pong_geom_pkg::Y_W:3] == '0)
				dir_n = deflect(d_r[2:0], pong_rules_pkg::DIR_UL, pong_rules_pkg::DIR_L,
					pong_rules_pkg::DIR_DL);
			if (ball_y == '0) begin
				if (dir_n == pong_rules_pkg::DIR_UL) dir_n = pong_rules_pkg::DIR_DL;
				else if (dir_n == pong_rules_pkg::DIR_UR) dir_n = pong_rules_pkg::DIR_DR;
			end else if (ball_y == pong_geom_pkg::BALL_Y_MAX) begin
				if (dir_n == pong_rules_pkg::DIR_DL) dir_n = pong_rules_pkg::DIR_UL;
				else if (dir_n == pong_rules_pkg::DIR_DR) dir_n = pong_rules_pkg::DIR_UR;
			end
			case (dir_n)
				pong_rules_pkg::DIR_L: ball_x_n = ball_x - 1'b1;
				pong_rules_pkg::DIR_R: ball_x_n = ball_x + 1'b1;
				pong_rules_pkg::DIR_UL: begin
					ball_x_n = ball_x - 1'b1;
					ball_y_n = ball_y - 1'b1;
				end
				pong_rules_pkg::DIR_UR: begin
					ball_x_n = ball_x + 1'b1;
					ball_y_n = ball_y - 1'b1;
				end
				pong_rules_pkg::DIR_DR: begin
					ball_x_n = ball_x + 1'b1;
					ball_y_n = ball_y + 1'b1;
				end
				default: begin // DL
					ball_x_n = ball_x - 1'b1;
					ball_y_n = ball_y + 1'b1;
				end
			endcase
		end
		if (wrap) begin
			pl_n = pong_geom_pkg::PADDLE_Y_START;
			pr_n = pong_geom_pkg::PADDLE_Y_START;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			ball_x <= pong_geom_pkg::BALL_X_START;
			ball_y <= pong_geom_pkg::BALL_Y_START;
			dir <= pong_rules_pkg::DIR_L;
			paddle_l_y <= pong_geom_pkg::PADDLE_Y_START;
			paddle_r_y <= pong_geom_pkg::PADDLE_Y_START;
			score_l <= '0;
			score_r <= '0;
		end else if (step) begin
			ball_x <= ball_x_n;
			ball_y <= ball_y_n;
			dir <= dir_n;
			paddle_l_y <= pl_n;
			paddle_r_y <= pr_n;
			score_l <= sl_n;
			score_r <= sr_n;
		end
	end

	a_ball_in_field: assert property (@(posedge clk) disable iff (!reset_n)
		ball_y <= pong_geom_pkg::BALL_Y_MAX)
		else $error("ball left the field vertically");

endmodule

`default_nettype wire

//--- seg7_decoder.sv
// Hex digit to seven segments, active low, segment 0 is a and segment 6 is g
`timescale 1ns/100ps
`default_nettype none

module seg7_decoder (
	input logic [pong_rules_pkg::SCORE_W-1:0] value,
	output logic [6:0] segments
);

	always_comb begin
		case (value)
			4'h0: segments = 7'b1000000;
			4'h1: segments = 7'b1111001;
			4'h2: segments = 7'b0100100;
			4'h3: segments = 7'b0110000;
			4'h4: segments = 7'b0011001;
			4'h5: segments = 7'b0010010;
			4'h6: segments = 7'b0000010;
			4'h7: segments = 7'b1111000;
			4'h8: segments = 7'b0000000;
			4'h9: segments = 7'b0010000;
			4'hA: segments = 7'b0001000;
			4'hB: segments = 7'b0000011; // Lower case b
			4'hC: segments = 7'b1000110;
			4'hD: segments = 7'b0100001; // Lower case d
			4'hE: segments = 7'b0000110;
			default: segments = 7'b0001110;
		endcase
	end

endmodule

`default_nettype wire

//--- pong_top.sv
// Pong core for an external 160x120 frame buffer; buttons are active high and already debounced
`timescale 1ns/100ps
`default_nettype none

module pong_top #(
	parameter int TICKS_PER_FRAME = 100000
) (
	input logic clk,
	input logic reset_n,
	input logic go,
	input logic [pong_rules_pkg::SPEED_W-1:0] speed,
	input logic p1_up,
	input logic p1_down,
	input logic p2_up,
	input logic p2_down,
	input logic [pong_geom_pkg::COLOUR_W-1:0] p1_colour,
	input logic [pong_geom_pkg::COLOUR_W-1:0] p2_colour,
	output logic [pong_geom_pkg::X_W-1:0] pix_x,
	output logic [pong_geom_pkg::Y_W-1:0] pix_y,
	output logic [pong_geom_pkg::COLOUR_W-1:0] pix_colour,
	output logic plot,
	output logic [6:0] hex_l,
	output logic [6:0] hex_r
);

	logic paint_start;
	logic erase_mode;
	logic timer_start;
	logic step;
	logic paint_done;
	logic frame_tick;
	logic [pong_geom_pkg::X_W-1:0] ball_x;
	logic [pong_geom_pkg::Y_W-1:0] ball_y;
	logic [pong_geom_pkg::Y_W-1:0] paddle_l_y;
	logic [pong_geom_pkg::Y_W-1:0] paddle_r_y;
	logic [pong_rules_pkg::SCORE_W-1:0] score_l;
	logic [pong_rules_pkg::SCORE_W-1:0] score_r;

	game_fsm u_fsm (
		.clk(clk),
		.reset_n(reset_n),
		.go(go),
		.paint_done(paint_done),
		.frame_tick(frame_tick),
		.paint_start(paint_start),
		.erase_mode(erase_mode),
		.timer_start(timer_start),
		.step(step)
	);

	frame_timer #(
		.TICKS_PER_FRAME(TICKS_PER_FRAME)
	) u_timer (
		.clk(clk),
		.reset_n(reset_n),
		.timer_start(timer_start),
		.speed(speed),
		.frame_tick(frame_tick)
	);

	sprite_painter u_painter (
		.clk(clk),
		.reset_n(reset_n),
		.paint_start(paint_start),
		.erase_mode(erase_mode),
		.ball_x(ball_x),
		.ball_y(ball_y),
		.paddle_l_y(paddle_l_y),
		.paddle_r_y(paddle_r_y),
		.p1_colour(p1_colour),
		.p2_colour(p2_colour),
		.pix_x(pix_x),
		.pix_y(pix_y),
		.pix_colour(pix_colour),
		.plot(plot),
		.paint_done(paint_done)
	);

	play_field u_field (
		.clk(clk),
		.reset_n(reset_n),
		.step(step),
		.p1_up(p1_up),
		.p1_down(p1_down),
		.p2_up(p2_up),
		.p2_down(p2_down),
		.ball_x(ball_x),
		.ball_y(ball_y),
		.paddle_l_y(paddle_l_y),
		.paddle_r_y(paddle_r_y),
		.score_l(score_l),
		.score_r(score_r)
	);

	seg7_decoder u_hex_l (
		.value(score_l),
		.segments(hex_l)
	);

	seg7_decoder u_hex_r (
		.value(score_r),
		.segments(hex_r)
	);

endmodule

`default_nettype wire

//--- tb_pong.sv
// Random play against pong_top with TICKS_PER_FRAME of 4; player buttons follow a tracking rule with random aim
`timescale 1ns/100ps
`default_nettype none

module tb_pong;

	localparam int TICKS = 4;
	localparam int NUM_FRAMES = 16000; // Long enough for scores to wrap and every zone to be hit
	localparam int PIXELS = pong_geom_pkg::SPRITE_PIXELS;
	// Two bursts, the handshake cycles and the slowest period
	localparam int WORST_FRAME = 2 * PIXELS + 4 + TICKS * pong_rules_pkg::MULT_SLOW;
	localparam int TIMEOUT_NS = (NUM_FRAMES * WORST_FRAME + 200) * 20 * 2;
	localparam int MISS_AIM = 12; // Paddle top held clear of the ball

	logic clk;
	logic reset_n;
	logic go;
	logic [pong_rules_pkg::SPEED_W-1:0] speed;
	logic p1_up;
	logic p1_down;
	logic p2_up;
	logic p2_down;
	logic [pong_geom_pkg::COLOUR_W-1:0] p1_colour;
	logic [pong_geom_pkg::COLOUR_W-1:0] p2_colour;
	logic [pong_geom_pkg::X_W-1:0] pix_x;
	logic [pong_geom_pkg::Y_W-1:0] pix_y;
	logic [pong_geom_pkg::COLOUR_W-1:0] pix_colour;
	logic plot;
	logic [6:0] hex_l;
	logic [6:0] hex_r;

	logic [31:0] lfsr_state;
	logic [3:0] speeds_seen;
	int checks;
	int value_errors;
	int other_errors;
	int m_bx; // Model state
	int m_by;
	int m_dir;
	int m_pl;
	int m_pr;
	int m_sl;
	int m_sr;
	int aim_l;
	int aim_r;
	int cur_n;
	int zones_l[3];
	int zones_r[3];
	int bounces;
	int wraps;
	int exp_x[PIXELS];
	int exp_y[PIXELS];

	pong_top #(
		.TICKS_PER_FRAME(TICKS)
	) uut (
		.clk(clk),
		.reset_n(reset_n),
		.go(go),
		.speed(speed),
		.p1_up(p1_up),
		.p1_down(p1_down),
		.p2_up(p2_up),
		.p2_down(p2_down),
		.p1_colour(p1_colour),
		.p2_colour(p2_colour),
		.pix_x(pix_x),
		.pix_y(pix_y),
		.pix_colour(pix_colour),
		.plot(plot),
		.hex_l(hex_l),
		.hex_r(hex_r)
	);

	always #10 clk = ~clk;

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int k;
		v = '0;
		for (k = 0; k < n; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic int speed_mult(input logic [1:0] s);
		if (s == 2'd0) return pong_rules_pkg::MULT_NORMAL;
		if (s == 2'd1) return pong_rules_pkg::MULT_SLOW;
		return pong_rules_pkg::MULT_FAST;
	endfunction

	function automatic int dir_dx(input int d);
		if (d == pong_rules_pkg::DIR_L || d == pong_rules_pkg::DIR_UL || d == pong_rules_pkg::DIR_DL)
			return -1;
		if (d == pong_rules_pkg::DIR_R || d == pong_rules_pkg::DIR_UR || d == pong_rules_pkg::DIR_DR)
			return 1;
		return 0;
	endfunction

	function automatic int dir_dy(input int d);
		if (d == pong_rules_pkg::DIR_UL || d == pong_rules_pkg::DIR_UR || d == pong_rules_pkg::DIR_U)
			return -1;
		if (d == pong_rules_pkg::DIR_DL || d == pong_rules_pkg::DIR_DR || d == pong_rules_pkg::DIR_D)
			return 1;
		return 0;
	endfunction

	function automatic int flip_vertical(input int d);
		if (d == pong_rules_pkg::DIR_UL) return pong_rules_pkg::DIR_DL;
		if (d == pong_rules_pkg::DIR_DL) return pong_rules_pkg::DIR_UL;
		if (d == pong_rules_pkg::DIR_UR) return pong_rules_pkg::DIR_DR;
		if (d == pong_rules_pkg::DIR_DR) return pong_rules_pkg::DIR_UR;
		return d;
	endfunction

	function automatic int paddle_move(input int y, input logic up, input logic down);
		if (down && y < pong_geom_pkg::PADDLE_Y_MAX) return y + 1;
		if (up && y > 0) return y - 1;
		return y;
	endfunction

	function automatic int zone_of(input int d);
		return (d <= 2) ? 0 : (d <= 4) ? 1 : 2;
	endfunction

	// Active low, bit 0 is segment a
	function automatic int hex_segments(input int v);
		case (v)
			0: return 7'b1000000;
			1: return 7'b1111001;
			2: return 7'b0100100;
			3: return 7'b0110000;
			4: return 7'b0011001;
			5: return 7'b0010010;
			6: return 7'b0000010;
			7: return 7'b1111000;
			8: return 7'b0000000;
			9: return 7'b0010000;
			10: return 7'b0001000;
			11: return 7'b0000011;
			12: return 7'b1000110;
			13: return 7'b0100001;
			14: return 7'b0000110;
			default: return 7'b0001110;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual, input int expected);
		checks++;
		if (actual !== expected) begin
			value_errors++;
			$display("[FAIL] %0t ns %s: got %0d, expected %0d", $time, name, actual, expected);
		end
	endtask

	// Deflection is resolved before the wall test
	task automatic model_step;
		int nl;
		int nr;
		int d;
		logic wrapped;
		nl = paddle_move(m_pl, p1_up, p1_down);
		nr = paddle_move(m_pr, p2_up, p2_down);
		wrapped = 1'b0;
		if (m_bx == 0 || m_bx >= pong_geom_pkg::PADDLE_R_X) begin
			if (m_bx == 0) begin
				wrapped = m_sr == pong_rules_pkg::SCORE_MAX;
				m_sr = wrapped ? 0 : m_sr + 1;
			end else begin
				wrapped = m_sl == pong_rules_pkg::SCORE_MAX;
				m_sl = wrapped ? 0 : m_sl + 1;
			end
			m_bx = pong_geom_pkg::BALL_X_START;
			m_by = pong_geom_pkg::BALL_Y_START;
			m_dir = pong_rules_pkg::DIR_L;
		end else begin
			d = m_by - m_pl;
			if (m_bx == pong_geom_pkg::HIT_X_L && dir_dx(m_dir) < 0 && d >= 0 && d <= 7) begin
				zones_l[zone_of(d)]++;
				m_dir = (d <= 2) ? pong_rules_pkg::DIR_UR : (d <= 4) ? pong_rules_pkg::DIR_R :
					pong_rules_pkg::DIR_DR;
			end
			d = m_by - m_pr;
			if (m_bx == pong_geom_pkg::HIT_X_R && dir_dx(m_dir) > 0 && d >= 0 && d <= 7) begin
				zones_r[zone_of(d)]++;
				m_dir = (d <= 2) ? pong_rules_pkg::DIR_UL : (d <= 4) ? pong_rules_pkg::DIR_L :
					pong_rules_pkg::DIR_DL;
			end
			if ((m_by == 0 && dir_dy(m_dir) < 0) ||
					(m_by == pong_geom_pkg::BALL_Y_MAX && dir_dy(m_dir) > 0)) begin
				m_dir = flip_vertical(m_dir);
				bounces++;
			end
			m_bx = m_bx + dir_dx(m_dir);
			m_by = m_by + dir_dy(m_dir);
		end
		if (wrapped) begin
			nl = pong_geom_pkg::PADDLE_Y_START;
			nr = pong_geom_pkg::PADDLE_Y_START;
			wraps++;
		end
		m_pl = nl;
		m_pr = nr;
	endtask

	// Move the paddle top towards ball row minus aim
	task automatic steer(input int paddle, input int aim, output logic up, output logic down);
		int target;
		logic [1:0] r;
		target = m_by - aim;
		r = 2'(rand_bits(2));
		if (paddle > target) begin
			up = 1'b1;
			down = 1'b0;
		end else if (paddle < target) begin
			up = 1'b0;
			down = 1'b1;
		end else begin
			up = r[0];
			down = r[1];
		end
	endtask

	task automatic drive_frame_inputs;
		speed = 2'(rand_bits(2));
		speeds_seen[speed] = 1'b1;
		cur_n = TICKS * speed_mult(speed);
		p1_colour = 3'(rand_bits(3));
		p2_colour = 3'(rand_bits(3));
		go = 1'(rand_bits(1)); // Ignored once running
		if (m_bx == pong_geom_pkg::BALL_X_START) begin
			aim_l = (rand_bits(2) != 0) ? MISS_AIM : int'(rand_bits(3)); // Weak left player
			aim_r = (rand_bits(3) == 0) ? MISS_AIM : int'(rand_bits(3));
		end
		steer(m_pl, aim_l, p1_up, p1_down);
		steer(m_pr, aim_r, p2_up, p2_down);
	endtask

	task automatic expected_pixel(input int i, output int x, output int y, output int c);
		int j;
		if (i < 4) begin
			x = m_bx + i % 2;
			y = m_by + i / 2;
			c = pong_geom_pkg::COLOUR_BALL;
		end else if (i < 20) begin
			j = i - 4;
			x = pong_geom_pkg::PADDLE_L_X + j % 2;
			y = m_pl + j / 2;
			c = p1_colour;
		end else begin
			j = i - 20;
			x = pong_geom_pkg::PADDLE_R_X + j % 2;
			y = m_pr + j / 2;
			c = p2_colour;
		end
	endtask

	// Entered on the negedge of the first draw write
	task automatic check_draw_burst;
		int i;
		int ex;
		int ey;
		int ec;
		for (i = 0; i < PIXELS; i++) begin
			if (i > 0) @(negedge clk);
			expected_pixel(i, ex, ey, ec);
			check_value("plot", plot, 1);
			check_value("pix_x", pix_x, ex);
			check_value("pix_y", pix_y, ey);
			check_value("pix_colour", pix_colour, ec);
			exp_x[i] = ex;
			exp_y[i] = ey;
			if (i == 0) drive_frame_inputs();
		end
	endtask

	task automatic check_erase_burst;
		int i;
		for (i = 0; i < PIXELS; i++) begin
			if (i > 0) @(negedge clk);
			check_value("plot", plot, 1);
			check_value("pix_x", pix_x, exp_x[i]);
			check_value("pix_y", pix_y, exp_y[i]);
			check_value("pix_colour", pix_colour, pong_geom_pkg::COLOUR_BLACK);
		end
	endtask

	task automatic wait_for_plot(output int cycles);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (plot !== 1'b1);
	endtask

	task automatic check_scores;
		check_value("hex_l", hex_l, hex_segments(m_sl));
		check_value("hex_r", hex_r, hex_segments(m_sr));
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the game did not finish %0d frames within %0d ns", NUM_FRAMES, TIMEOUT_NS);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		int gap;
		int idle;
		int f;
		clk = 1'b0;
		reset_n = 1'b0;
		go = 1'b0;
		speed = '0;
		p1_up = 1'b0;
		p1_down = 1'b0;
		p2_up = 1'b0;
		p2_down = 1'b0;
		p1_colour = '0;
		p2_colour = '0;
		lfsr_state = 32'h126;
		speeds_seen = '0;
		m_bx = pong_geom_pkg::BALL_X_START;
		m_by = pong_geom_pkg::BALL_Y_START;
		m_dir = pong_rules_pkg::DIR_L;
		m_pl = pong_geom_pkg::PADDLE_Y_START;
		m_pr = pong_geom_pkg::PADDLE_Y_START;
		m_sl = 0;
		m_sr = 0;
		aim_l = 0;
		aim_r = 0;
		repeat (2) begin
			@(negedge clk);
			check_value("plot", plot, 0);
		end
		reset_n = 1'b1;
		idle = 2 + int'(rand_bits(4));
		repeat (idle) begin
			@(negedge clk);
			check_value("plot", plot, 0);
		end
		go = 1'b1;
		@(negedge clk);
		check_value("plot", plot, 0);
		go = 1'b0;
		@(negedge clk); // First draw write due here
		for (f = 0; f < NUM_FRAMES; f++) begin
			check_scores();
			check_draw_burst();
			wait_for_plot(gap);
			check_value("erase gap", gap, cur_n + 2);
			check_erase_burst();
			model_step();
			wait_for_plot(gap);
			check_value("draw gap", gap, 2);
		end
		check_scores();
		if (speeds_seen != 4'hF) begin
			other_errors++;
			$display("Not every speed code was used during the run");
		end
		if (zones_l[0] == 0 || zones_l[1] == 0 || zones_l[2] == 0 ||
				zones_r[0] == 0 || zones_r[1] == 0 || zones_r[2] == 0) begin
			other_errors++;
			$display("Not every paddle deflection zone was hit during the run");
		end
		if (bounces == 0) begin
			other_errors++;
			$display("The ball never bounced off a wall during the run");
		end
		if (wraps == 0) begin
			other_errors++;
			$display("No score wrapped from 15 to 0 during the run");
		end
		$display("Coverage: left zones %0d/%0d/%0d, right zones %0d/%0d/%0d, bounces %0d, wraps %0d",
			zones_l[0], zones_l[1], zones_l[2], zones_r[0], zones_r[1], zones_r[2], bounces, wraps);
		$display("Checks %0d, value errors %0d, other errors %0d", checks, value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
pong_geom_pkg.sv
pong_rules_pkg.sv
frame_timer.sv
game_fsm.sv
sprite_painter.sv
play_field.sv
seg7_decoder.sv
pong_top.sv
tb_pong.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the pong testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_pong \
	-f verilog.f -Mdir obj_dir -o tb_pong > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_pong > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

if grep -q "Simulation failed" sim.log; then
	exit 1
fi
exit 0
